// File: list.f
verilog/ooo_pkg.sv
verilog/rs_bank.sv
verilog/allocator.sv
verilog/stage_issue.sv
verilog/execute.sv
verilog/cdb_arbiter.sv
verilog/issue_core.sv
verification/issue_core_tb.sv

// File: verification/issue_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module issue_core_tb;
    import ooo_pkg::*;

    localparam int ALU_RS_DEPTH  = 4;
    localparam int MULT_RS_DEPTH = 2;
    localparam int NUM_ALU       = 2;
    localparam int RESET_CYCLES  = 10;
    localparam int NUM_TAGS      = 1 << TAG_W;
    localparam int PHASE_LEN     = 24;

    typedef enum logic [1:0] {tag_free, tag_pending, tag_done, tag_flushed} tag_state_e;

    logic      clock;
    logic      rst;
    logic      flush;
    rs_entry_t dispatch_alu;
    rs_entry_t dispatch_mult;
    logic      alu_full;
    logic      mult_full;
    cdb_t      cdb;

    // Reference model, indexed by tag
    tag_state_e        state      [NUM_TAGS];
    logic [DATA_W-1:0] expect_val [NUM_TAGS];
    int                src_dep    [NUM_TAGS][2];

    logic [31:0] rng = 32'd3497;
    int          cyc = 0;
    int          n_disp = 0;
    int          n_bcast = 0;
    int          mismatches = 0;
    int          failures = 0;
    bit          alu_sent = 1'b0;
    bit          mult_sent = 1'b0;
    int          last_alu_tag = -1;
    int          last_mult_tag = -1;

    issue_core #(
        .ALU_RS_DEPTH (ALU_RS_DEPTH), .MULT_RS_DEPTH (MULT_RS_DEPTH), .NUM_ALU (NUM_ALU)
    ) UUT (
        .clock (clock), .rst (rst), .flush (flush),
        .dispatch_alu (dispatch_alu), .dispatch_mult (dispatch_mult),
        .alu_full (alu_full), .mult_full (mult_full), .cdb (cdb)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Results wrap to DATA_W bits and products keep their low half
    function automatic logic [DATA_W-1:0] model_result(input alu_op_e op,
                                                       input logic [DATA_W-1:0] a,
                                                       input logic [DATA_W-1:0] b);
        logic [2*DATA_W-1:0] wide;
        case (op)
            op_add:  wide = a + b;
            op_sub:  wide = a - b;
            op_and:  wide = a & b;
            op_or:   wide = a | b;
            op_xor:  wide = a ^ b;
            op_mul:  wide = a * b;
            default: wide = '0;
        endcase
        return wide[DATA_W-1:0];
    endfunction

    function automatic int fresh_tag();
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (state[i] == tag_free) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int find_pending();
        int start;
        int t;
        start = int'(next_rand() % NUM_TAGS);
        for (int i = 0; i < NUM_TAGS; i++) begin
            t = (start + i) % NUM_TAGS;
            if (state[t] == tag_pending) begin
                return t;
            end
        end
        return -1;
    endfunction

    function automatic int count_pending();
        int n;
        n = 0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (state[i] == tag_pending) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic void release_tags();
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (state[i] != tag_pending) begin
                state[i] = tag_free;
            end
        end
    endfunction

    // wait_tag >= 0 waits on that tag, -1 picks at random, -2 forces a value
    task automatic pick_source(input int wait_tag, output logic rdy, output logic [TAG_W-1:0] tag,
                               output logic [DATA_W-1:0] val, output int dep);
        int cand;
        cand = -1;
        if (wait_tag >= 0 && state[wait_tag] == tag_pending) begin
            cand = wait_tag;
        end else if (wait_tag == -1 && next_rand() % 3 == 0) begin
            cand = find_pending();
        end
        dep = cand;
        rdy = (cand < 0);
        tag = (cand >= 0) ? TAG_W'(cand) : '0;
        // Small operands now and then so some products fit without truncation
        val = (next_rand() % 4 == 0) ? DATA_W'(next_rand() % 8) : DATA_W'(next_rand());
    endtask

    task automatic build_entry(input alu_op_e op, input int wait_tag, input int tag,
                               output rs_entry_t e);
        logic              r1, r2;
        logic [TAG_W-1:0]  t1, t2;
        logic [DATA_W-1:0] v1, v2;
        int                d1, d2;
        pick_source(wait_tag, r1, t1, v1, d1);
        pick_source((wait_tag >= 0) ? -2 : wait_tag, r2, t2, v2, d2);
        e = '{valid: 1'b1, op: op, dest: TAG_W'(tag),
              src1_ready: r1, src1_tag: t1, src1_val: v1,
              src2_ready: r2, src2_tag: t2, src2_val: v2};
        expect_val[tag] = model_result(op, (d1 >= 0) ? expect_val[d1] : v1,
                                       (d2 >= 0) ? expect_val[d2] : v2);
        src_dep[tag][0] = d1;
        src_dep[tag][1] = d2;
        state[tag] = tag_pending;
        n_disp++;
    endtask

    // A bank only takes a dispatch every other cycle, so a flag read before the edge is safe
    task automatic dispatch_cycle(input bit try_alu, input bit try_mult,
                                  input int alu_wait, input int mult_wait);
        rs_entry_t ea;
        rs_entry_t em;
        int        t;
        ea = '0;
        em = '0;
        @(posedge clock);
        if (try_alu && !alu_full && !alu_sent) begin
            t = fresh_tag();
            if (t >= 0) begin
                build_entry(alu_op_e'(3'(next_rand() % 5)), alu_wait, t, ea);
                last_alu_tag = t;
            end
        end
        if (try_mult && !mult_full && !mult_sent) begin
            t = fresh_tag();
            if (t >= 0) begin
                build_entry(op_mul, mult_wait, t, em);
                last_mult_tag = t;
            end
        end
        dispatch_alu  <= ea;
        dispatch_mult <= em;
        alu_sent  = ea.valid;
        mult_sent = em.valid;
    endtask

    task automatic idle_cycle();
        @(posedge clock);
        dispatch_alu  <= '0;
        dispatch_mult <= '0;
        alu_sent  = 1'b0;
        mult_sent = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle_cycle();
        while (count_pending() != 0 && waited < 200) begin
            @(posedge clock);
            waited++;
        end
        a_drained: assert (count_pending() == 0) else begin
            failures++;
            $display("At %0t, %0d dispatched tags were never broadcast", $time, count_pending());
        end
        release_tags();
    endtask

    task automatic random_traffic(input int count);
        int start;
        start = n_disp;
        while (n_disp - start < count) begin
            dispatch_cycle(next_rand() % 4 != 0, next_rand() % 3 == 0, -1, -1);
        end
    endtask

    task automatic flush_pipeline();
        rs_entry_t ea;
        int        t;
        ea = '0;
        @(posedge clock);
        // Dispatch alongside the flush must be dropped
        t = fresh_tag();
        if (t >= 0) begin
            build_entry(op_add, -2, t, ea);
            state[t] = tag_flushed;
        end
        flush         <= 1'b1;
        dispatch_alu  <= ea;
        dispatch_mult <= '0;
        idle_cycle();
        flush <= 1'b0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (state[i] == tag_pending) begin
                state[i] = tag_flushed;
            end
        end
        repeat (20) @(posedge clock);
        release_tags();
    endtask

    task automatic check_full_drops(input bit mult_bank, input int producer);
        int   waited;
        logic f;
        waited = 0;
        f = 1'b1;
        while (f && waited < 100) begin
            @(posedge clock);
            f = mult_bank ? mult_full : alu_full;
            waited++;
        end
        a_full_drop: assert (!f) else begin
            failures++;
            $display("Full flag of bank %0d never dropped after the bank filled", mult_bank);
        end
        a_full_after_producer: assert (state[producer] == tag_done) else begin
            failures++;
            $display("Full flag of bank %0d dropped before tag %0d was broadcast",
                     mult_bank, producer);
        end
    endtask

    task automatic fill_alu_bank(input bit flush_when_full);
        int chain;
        chain = -2;
        // Chained multiplies give a producer that resolves late
        for (int k = 0; k < 4; ) begin
            dispatch_cycle(1'b0, 1'b1, -2, chain);
            if (mult_sent) begin
                chain = last_mult_tag;
                k++;
            end
        end
        for (int k = 0; k < ALU_RS_DEPTH; ) begin
            dispatch_cycle(1'b1, 1'b0, chain, -2);
            if (alu_sent) k++;
        end
        idle_cycle();
        @(posedge clock);
        a_alu_full: assert (alu_full) else begin
            mismatches++;
            $display("Mismatch at %0t: alu_full expected 1 got %b", $time, alu_full);
        end
        if (flush_when_full) begin
            // Flush hits a full bank while the last multiply is still in flight
            flush_pipeline();
        end else begin
            check_full_drops(1'b0, chain);
        end
    endtask

    task automatic fill_mult_bank();
        int m1;
        int x;
        m1 = -1;
        x  = -1;
        while (m1 < 0) begin
            dispatch_cycle(1'b0, 1'b1, -2, -2);
            if (mult_sent) m1 = last_mult_tag;
        end
        while (x < 0) begin
            dispatch_cycle(1'b1, 1'b0, m1, -2);
            if (alu_sent) x = last_alu_tag;
        end
        for (int k = 0; k < MULT_RS_DEPTH; ) begin
            dispatch_cycle(1'b0, 1'b1, -2, x);
            if (mult_sent) k++;
        end
        idle_cycle();
        @(posedge clock);
        a_mult_full: assert (mult_full) else begin
            mismatches++;
            $display("Mismatch at %0t: mult_full expected 1 got %b", $time, mult_full);
        end
        check_full_drops(1'b1, x);
    endtask

    task automatic report_counts();
        $display("Dispatched %0d, broadcast %0d, mismatches %0d, other errors %0d",
                 n_disp, n_bcast, mismatches, failures);
    endtask

    // Every broadcast is checked against the model
    always @(negedge clock) begin
        int t;
        int d;
        if (!rst && cdb.valid) begin
            t = int'(cdb.tag);
            a_tag_pending: assert (state[t] == tag_pending) else begin
                failures++;
                $display("At %0t, tag %0d was broadcast while no result was owed", $time, t);
            end
            if (state[t] == tag_pending) begin
                a_value: assert (cdb.value == expect_val[t]) else begin
                    mismatches++;
                    $display("Mismatch at %0t: cdb.value for tag %0d expected %h got %h",
                             $time, t, expect_val[t], cdb.value);
                end
                for (int s = 0; s < 2; s++) begin
                    d = src_dep[t][s];
                    if (d >= 0) begin
                        a_order: assert (state[d] == tag_done) else begin
                            failures++;
                            $display("At %0t, tag %0d was broadcast before its source tag %0d",
                                     $time, t, d);
                        end
                    end
                end
                state[t] = tag_done;
                n_bcast++;
            end
        end
    end

    a_quiet_after_clear: assert property (@(posedge clock)
        (rst || flush) |=> (!cdb.valid && !alu_full && !mult_full))
        else begin
            failures++;
            $display("At %0t, CDB or a full flag was active right after reset or flush", $time);
        end

    a_cdb_known: assert property (@(posedge clock) disable iff (rst)
        cdb.valid |-> !$isunknown({cdb.tag, cdb.value}))
        else begin
            failures++;
            $display("At %0t, the CDB carried unknown bits", $time);
        end

    initial begin : watchdog
        @(posedge clock);
        while (cyc < 40 * n_disp + 200 + RESET_CYCLES) begin
            @(posedge clock);
        end
        failures++;
        $display("Timeout, the run was still going after %0d cycles", cyc);
        report_counts();
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst           = 1'b1;
        flush         = 1'b0;
        dispatch_alu  = '0;
        dispatch_mult = '0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            state[i]      = tag_free;
            expect_val[i] = '0;
            src_dep[i][0] = -1;
            src_dep[i][1] = -1;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        rst <= 1'b0;
        idle_cycle();

        random_traffic(PHASE_LEN);
        drain();
        fill_alu_bank(1'b0);
        drain();
        fill_mult_bank();
        drain();
        fill_alu_bank(1'b1);
        random_traffic(12);
        flush_pipeline();
        random_traffic(PHASE_LEN);
        drain();
        random_traffic(8);
        flush_pipeline();
        random_traffic(PHASE_LEN);
        drain();

        report_counts();
        if (mismatches == 0 && failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/allocator.sv
`timescale 1ns/1ps
`default_nettype none

module allocator #(
    parameter int NUM_REQ = 4,
    parameter int NUM_RES = 2
) (
    input  logic                              clock,
    input  logic                              rst,
    input  logic                              flush,
    input  logic [NUM_REQ-1:0]                req,
    input  logic [NUM_RES-1:0]                unit_release,
    output logic [NUM_REQ-1:0][NUM_RES-1:0]   grant
);

    logic [NUM_RES-1:0] busy;
    logic [NUM_RES-1:0] avail;
    logic [NUM_RES-1:0] taken;

    // A unit finishing this cycle can take new work right away
    assign avail = ~busy | unit_release;

    always_comb begin
        logic [NUM_RES-1:0] left;
        left  = avail;
        grant = '0;
        for (int r = 0; r < NUM_REQ; r++) begin
            for (int u = 0; u < NUM_RES; u++) begin
                if (req[r] && left[u] && !(|grant[r])) begin
                    grant[r][u] = 1'b1;
                    left[u]     = 1'b0;
                end
            end
        end
        taken = avail & ~left;
    end

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~unit_release) | taken;
        end
    end

    for (genvar u = 0; u < NUM_RES; u++) begin : g_unit_chk
        logic [NUM_REQ-1:0] col;
        for (genvar r = 0; r < NUM_REQ; r++) begin : g_col
            assign col[r] = grant[r][u];
        end
        a_unit_once: assert property (@(posedge clock) disable iff (rst) $onehot0(col))
            else $error("unit %0d granted to more than one request", u);
    end

    for (genvar r = 0; r < NUM_REQ; r++) begin : g_req_chk
        a_req_once: assert property (@(posedge clock) disable iff (rst) $onehot0(grant[r]))
            else $error("request %0d granted more than one unit", r);
    end

endmodule

`default_nettype wire

// File: verilog/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter #(
    parameter int NUM_ALU = 2
) (
    input  logic                                     clock,
    input  logic                                     rst,
    input  logic                                     flush,
    input  logic [NUM_ALU-1:0]                       alu_req,
    input  ooo_pkg::rs_entry_t [NUM_ALU-1:0]         alu_slots,
    input  logic [NUM_ALU-1:0][ooo_pkg::DATA_W-1:0]  alu_results,
    input  logic                                     mult_req,
    input  ooo_pkg::cdb_t                            mult_result,
    output logic [NUM_ALU-1:0]                       alu_grant,
    output logic                                     mult_grant,
    output ooo_pkg::cdb_t                            cdb
);
    import ooo_pkg::*;

    // ALU units first, multiplier last in the ring
    localparam int NUM_REQ = NUM_ALU + 1;
    localparam int PTR_W   = $clog2(NUM_REQ);

    logic [PTR_W-1:0]   ptr;
    logic [PTR_W-1:0]   winner;
    logic [NUM_REQ-1:0] req_vec;
    logic [NUM_REQ-1:0] gnt_vec;

    assign req_vec = {mult_req, alu_req};

    always_comb begin
        int   idx;
        logic found;
        found   = 1'b0;
        gnt_vec = '0;
        winner  = '0;
        for (int k = 0; k < NUM_REQ; k++) begin
            idx = int'(ptr) + k;
            if (idx >= NUM_REQ) begin
                idx = idx - NUM_REQ;
            end
            if (!found && req_vec[idx]) begin
                found        = 1'b1;
                gnt_vec[idx] = 1'b1;
                winner       = PTR_W'(idx);
            end
        end
    end

    assign alu_grant  = gnt_vec[NUM_ALU-1:0];
    assign mult_grant = gnt_vec[NUM_ALU];

    // Broadcast goes out in the grant cycle
    always_comb begin
        cdb       = '0;
        cdb.valid = |gnt_vec;
        if (mult_grant) begin
            cdb.tag   = mult_result.tag;
            cdb.value = mult_result.value;
        end
        for (int u = 0; u < NUM_ALU; u++) begin
            if (alu_grant[u]) begin
                cdb.tag   = alu_slots[u].dest;
                cdb.value = alu_results[u];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            ptr <= '0;
        end else if (|gnt_vec) begin
            ptr <= (winner == PTR_W'(NUM_ALU)) ? '0 : winner + 1'b1;
        end
    end

    a_grant_onehot: assert property (@(posedge clock) disable iff (rst)
        $onehot0(gnt_vec) && ((gnt_vec & ~req_vec) == '0))
        else $error("CDB grant not one-hot or given without a request");

endmodule

`default_nettype wire

// File: verilog/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute #(
    parameter int NUM_ALU = 2
) (
    input  logic                                       clock,
    input  logic                                       rst,
    input  logic                                       flush,
    input  ooo_pkg::rs_entry_t [NUM_ALU-1:0]           alu_slots,
    input  ooo_pkg::rs_entry_t                         mult_slot,
    input  logic                                       mult_grant,
    output logic [NUM_ALU-1:0][ooo_pkg::DATA_W-1:0]    alu_results,
    output logic                                       mult_accept,
    output logic                                       mult_req,
    output ooo_pkg::cdb_t                              mult_result
);
    import ooo_pkg::*;

    localparam int HALF_W = DATA_W / 2;

    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
    } mul_op_t;

    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] lo;
        logic [HALF_W-1:0] hi;
    } mul_part_t;

    mul_op_t   m1;
    mul_part_t m2;
    cdb_t      m3;
    logic      advance;

    function automatic logic [DATA_W-1:0] alu_eval(alu_op_e op, logic [DATA_W-1:0] a,
                                                   logic [DATA_W-1:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            default: return '0;
        endcase
    endfunction

    always_comb begin
        for (int u = 0; u < NUM_ALU; u++) begin
            alu_results[u] = alu_eval(alu_slots[u].op, alu_slots[u].src1_val,
                                      alu_slots[u].src2_val);
        end
    end

    // Whole pipe holds while stage 3 waits for the CDB
    assign advance     = !m3.valid || mult_grant;
    assign mult_accept = advance && mult_slot.valid;
    assign mult_req    = m3.valid;
    assign mult_result = m3;

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            m1.valid <= 1'b0;
            m2.valid <= 1'b0;
            m3.valid <= 1'b0;
        end else if (advance) begin
            m1.valid <= mult_slot.valid;
            m1.tag   <= mult_slot.dest;
            m1.a     <= mult_slot.src1_val;
            m1.b     <= mult_slot.src2_val;

            // Split on b; the high half only matters in its low bits after the shift
            m2.valid <= m1.valid;
            m2.tag   <= m1.tag;
            m2.lo    <= m1.a * m1.b[HALF_W-1:0];
            m2.hi    <= m1.a[HALF_W-1:0] * m1.b[DATA_W-1:HALF_W];

            m3.valid <= m2.valid;
            m3.tag   <= m2.tag;
            m3.value <= m2.lo + {m2.hi, {HALF_W{1'b0}}};
        end
    end

endmodule

`default_nettype wire

// File: verilog/issue_core.sv
`timescale 1ns/1ps
`default_nettype none

module issue_core #(
    parameter int ALU_RS_DEPTH  = 4,
    parameter int MULT_RS_DEPTH = 2,
    parameter int NUM_ALU       = 2
) (
    input  logic               clock,
    input  logic               rst,
    input  logic               flush,
    input  ooo_pkg::rs_entry_t dispatch_alu,
    input  ooo_pkg::rs_entry_t dispatch_mult,
    output logic               alu_full,
    output logic               mult_full,
    output ooo_pkg::cdb_t      cdb
);
    import ooo_pkg::*;

    rs_entry_t [ALU_RS_DEPTH-1:0]   alu_entries;
    rs_entry_t [MULT_RS_DEPTH-1:0]  mult_entries;
    logic [ALU_RS_DEPTH-1:0]        alu_clear;
    logic [MULT_RS_DEPTH-1:0]       mult_clear;
    rs_entry_t [NUM_ALU-1:0]        alu_slots;
    rs_entry_t                      mult_slot;
    logic [NUM_ALU-1:0]             alu_req;
    logic [NUM_ALU-1:0]             alu_grant;
    logic [NUM_ALU-1:0][DATA_W-1:0] alu_results;
    logic                           mult_accept;
    logic                           mult_req;
    logic                           mult_grant;
    cdb_t                           mult_result;

    rs_bank #(.DEPTH(ALU_RS_DEPTH)) u_alu_rs (
        .clock (clock), .rst (rst), .flush (flush),
        .dispatch (dispatch_alu), .cdb (cdb), .clear (alu_clear),
        .entries (alu_entries), .full (alu_full)
    );

    rs_bank #(.DEPTH(MULT_RS_DEPTH)) u_mult_rs (
        .clock (clock), .rst (rst), .flush (flush),
        .dispatch (dispatch_mult), .cdb (cdb), .clear (mult_clear),
        .entries (mult_entries), .full (mult_full)
    );

    stage_issue #(
        .ALU_RS_DEPTH (ALU_RS_DEPTH), .MULT_RS_DEPTH (MULT_RS_DEPTH), .NUM_ALU (NUM_ALU)
    ) u_issue (
        .clock (clock), .rst (rst), .flush (flush),
        .alu_entries (alu_entries), .mult_entries (mult_entries),
        .alu_grant (alu_grant), .mult_accept (mult_accept),
        .alu_clear (alu_clear), .mult_clear (mult_clear),
        .alu_slots (alu_slots), .mult_slot (mult_slot), .alu_req (alu_req)
    );

    execute #(.NUM_ALU(NUM_ALU)) u_execute (
        .clock (clock), .rst (rst), .flush (flush),
        .alu_slots (alu_slots), .mult_slot (mult_slot), .mult_grant (mult_grant),
        .alu_results (alu_results), .mult_accept (mult_accept),
        .mult_req (mult_req), .mult_result (mult_result)
    );

    cdb_arbiter #(.NUM_ALU(NUM_ALU)) u_cdb_arb (
        .clock (clock), .rst (rst), .flush (flush),
        .alu_req (alu_req), .alu_slots (alu_slots), .alu_results (alu_results),
        .mult_req (mult_req), .mult_result (mult_result),
        .alu_grant (alu_grant), .mult_grant (mult_grant), .cdb (cdb)
    );

endmodule

`default_nettype wire

// File: verilog/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int TAG_W   = 5;
    localparam int DATA_W  = 16;
    // Widest ALU unit count the busy summary can describe
    localparam int MAX_ALU = 4;

    // The bank picks the unit class, op_mul only lives in the multiplier bank
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_mul = 3'd5
    } alu_op_e;

    typedef struct packed {
        logic              valid;
        alu_op_e           op;
        logic [TAG_W-1:0]  dest;
        logic              src1_ready;
        logic [TAG_W-1:0]  src1_tag;
        logic [DATA_W-1:0] src1_val;
        logic              src2_ready;
        logic [TAG_W-1:0]  src2_tag;
        logic [DATA_W-1:0] src2_val;
    } rs_entry_t;

    // One result broadcast
    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic               mult;
        logic [MAX_ALU-1:0] alu;
    } fu_busy_t;

endpackage

`default_nettype wire

// File: verilog/rs_bank.sv
`timescale 1ns/1ps
`default_nettype none

module rs_bank #(
    parameter int DEPTH = 4
) (
    input  logic                           clock,
    input  logic                           rst,
    input  logic                           flush,
    input  ooo_pkg::rs_entry_t             dispatch,
    input  ooo_pkg::cdb_t                  cdb,
    input  logic [DEPTH-1:0]               clear,
    output ooo_pkg::rs_entry_t [DEPTH-1:0] entries,
    output logic                           full
);
    import ooo_pkg::*;

    logic [DEPTH-1:0] occupied;
    logic [DEPTH-1:0] ins_sel;

    // Take the broadcast value for any source still waiting on that tag
    function automatic rs_entry_t wake(rs_entry_t e, cdb_t bc);
        rs_entry_t w;
        w = e;
        if (bc.valid && !e.src1_ready && e.src1_tag == bc.tag) begin
            w.src1_ready = 1'b1;
            w.src1_val   = bc.value;
        end
        if (bc.valid && !e.src2_ready && e.src2_tag == bc.tag) begin
            w.src2_ready = 1'b1;
            w.src2_val   = bc.value;
        end
        return w;
    endfunction

    // Lowest empty entry gets the next dispatch
    always_comb begin
        logic found;
        found   = 1'b0;
        ins_sel = '0;
        for (int i = 0; i < DEPTH; i++) begin
            occupied[i] = entries[i].valid;
            if (!occupied[i] && !found) begin
                ins_sel[i] = 1'b1;
                found      = 1'b1;
            end
        end
    end

    assign full = &occupied;

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (dispatch.valid && ins_sel[i]) begin
                    // A same-cycle broadcast is caught on the way in
                    entries[i] <= wake(dispatch, cdb);
                end else begin
                    entries[i] <= wake(entries[i], cdb);
                    if (clear[i]) begin
                        entries[i].valid <= 1'b0;
                    end
                end
            end
        end
    end

    a_no_dispatch_full: assert property (@(posedge clock) disable iff (rst || flush)
        dispatch.valid |-> !full)
        else $error("dispatch into a full reservation-station bank");

endmodule

`default_nettype wire

// File: verilog/stage_issue.sv
`timescale 1ns/1ps
`default_nettype none

module stage_issue #(
    parameter int ALU_RS_DEPTH  = 4,
    parameter int MULT_RS_DEPTH = 2,
    parameter int NUM_ALU       = 2
) (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic                                   flush,
    input  ooo_pkg::rs_entry_t [ALU_RS_DEPTH-1:0]  alu_entries,
    input  ooo_pkg::rs_entry_t [MULT_RS_DEPTH-1:0] mult_entries,
    input  logic [NUM_ALU-1:0]                     alu_grant,
    input  logic                                   mult_accept,
    output logic [ALU_RS_DEPTH-1:0]                alu_clear,
    output logic [MULT_RS_DEPTH-1:0]               mult_clear,
    output ooo_pkg::rs_entry_t [NUM_ALU-1:0]       alu_slots,
    output ooo_pkg::rs_entry_t                     mult_slot,
    output logic [NUM_ALU-1:0]                     alu_req
);
    import ooo_pkg::*;

    logic [ALU_RS_DEPTH-1:0]               alu_ready;
    logic [MULT_RS_DEPTH-1:0]              mult_ready;
    logic [ALU_RS_DEPTH-1:0][NUM_ALU-1:0]  alu_gnt;
    logic [MULT_RS_DEPTH-1:0][0:0]         mult_gnt;
    logic [NUM_ALU-1:0]                    alu_load;
    fu_busy_t                              slot_busy;

    function automatic logic is_ready(rs_entry_t e);
        return e.valid && e.src1_ready && e.src2_ready;
    endfunction

    if (NUM_ALU > MAX_ALU) begin : g_bad_cfg
        $error("NUM_ALU larger than the busy summary allows");
    end

    always_comb begin
        for (int r = 0; r < ALU_RS_DEPTH; r++) begin
            alu_ready[r] = is_ready(alu_entries[r]);
        end
        for (int r = 0; r < MULT_RS_DEPTH; r++) begin
            mult_ready[r] = is_ready(mult_entries[r]);
        end
    end

    // ALU units free up on their CDB grant
    allocator #(
        .NUM_REQ (ALU_RS_DEPTH),
        .NUM_RES (NUM_ALU)
    ) u_alu_alloc (
        .clock        (clock),
        .rst          (rst),
        .flush        (flush),
        .req          (alu_ready),
        .unit_release (alu_grant),
        .grant        (alu_gnt)
    );

    // Multiplier frees its slot when the pipeline takes the entry
    allocator #(
        .NUM_REQ (MULT_RS_DEPTH),
        .NUM_RES (1)
    ) u_mult_alloc (
        .clock        (clock),
        .rst          (rst),
        .flush        (flush),
        .req          (mult_ready),
        .unit_release (mult_accept),
        .grant        (mult_gnt)
    );

    always_comb begin
        alu_load = '0;
        for (int r = 0; r < ALU_RS_DEPTH; r++) begin
            alu_clear[r] = |alu_gnt[r];
            alu_load     = alu_load | alu_gnt[r];
        end
        for (int r = 0; r < MULT_RS_DEPTH; r++) begin
            mult_clear[r] = mult_gnt[r][0];
        end
    end

    // A load on the same edge as a release wins over the release
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            for (int u = 0; u < NUM_ALU; u++) begin
                alu_slots[u].valid <= 1'b0;
            end
            mult_slot.valid <= 1'b0;
        end else begin
            for (int u = 0; u < NUM_ALU; u++) begin
                if (alu_grant[u]) begin
                    alu_slots[u].valid <= 1'b0;
                end
                for (int r = 0; r < ALU_RS_DEPTH; r++) begin
                    if (alu_gnt[r][u]) begin
                        alu_slots[u] <= alu_entries[r];
                    end
                end
            end
            if (mult_accept) begin
                mult_slot.valid <= 1'b0;
            end
            for (int r = 0; r < MULT_RS_DEPTH; r++) begin
                if (mult_gnt[r][0]) begin
                    mult_slot <= mult_entries[r];
                end
            end
        end
    end

    always_comb begin
        slot_busy = '0;
        for (int u = 0; u < NUM_ALU; u++) begin
            slot_busy.alu[u] = alu_slots[u].valid;
        end
        slot_busy.mult = mult_slot.valid;
    end

    assign alu_req = slot_busy.alu[NUM_ALU-1:0];

    // Allocator state has to agree with the slots and the execute side
    a_load_free_slot: assert property (@(posedge clock) disable iff (rst || flush)
        ((alu_load & slot_busy.alu[NUM_ALU-1:0] & ~alu_grant) == '0) &&
        (!(|mult_clear) || !slot_busy.mult || mult_accept))
        else $error("issue slot loaded while it still holds an unfinished entry");

endmodule

`default_nettype wire
